/* vlog.f */
cpuPkg.sv
cpuSequencer.sv
instDecoder.sv
regFile.sv
alu.sv
execUnit.sv
cpuTop.sv
cpuTop_assert.sv
cpuTop_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module cpuTop_tb -f vlog.f -o simv; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

/* cpuTop_tb.sv */
`default_nettype none

module cpuTop_tb
	import cpuPkg::*;
;

	localparam wordT DATA_BASE = 32'h0000_0100;
	localparam int DATA_WORDS = 16;

	logic clk;
	logic rst;
	wordT pc;
	logic instReqValid;
	logic instReqAck;
	wordT instruction;
	logic instValid;
	logic instAck;
	wordT address;
	logic memWrite;
	wordT writeData;
	logic memRead;
	logic memReqAck;
	wordT readData;
	logic readDataValid;
	logic readDataAck;

	// program trace, one entry per fetch
	wordT progInst[$];
	wordT progPc[$];
	bit progHasStore[$];
	wordT progStAddr[$];
	wordT progStData[$];
	int numEntries = 0;

	wordT dmem [DATA_WORDS];
	bit pendingStore;
	wordT expAddr;
	wordT expData;
	int cycles = 0;

	cpuTop i_cpuTop (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.instReqValid(instReqValid),
		.instReqAck(instReqAck),
		.instruction(instruction),
		.instValid(instValid),
		.instAck(instAck),
		.address(address),
		.memWrite(memWrite),
		.writeData(writeData),
		.memRead(memRead),
		.memReqAck(memReqAck),
		.readData(readData),
		.readDataValid(readDataValid),
		.readDataAck(readDataAck)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic wordT encR(int f7, int rs2, int rs1, int f3, int rd);
		encR = {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
	endfunction

	function automatic wordT encI(int imm, int rs1, int f3, int rd, logic [6:0] op);
		wordT i;
		i = wordT'(imm);
		encI = {i[11:0], 5'(rs1), 3'(f3), 5'(rd), op};
	endfunction

	function automatic wordT encS(int imm, int rs2, int rs1);
		wordT i;
		i = wordT'(imm);
		encS = {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], OP_STORE};
	endfunction

	function automatic wordT encB(int imm, int rs2, int rs1, int f3);
		wordT i;
		i = wordT'(imm);
		encB = {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], OP_BRANCH};
	endfunction

	function automatic wordT encU(int imm20, int rd, logic [6:0] op);
		wordT i;
		i = wordT'(imm20);
		encU = {i[19:0], 5'(rd), op};
	endfunction

	function automatic wordT encJ(int imm, int rd);
		wordT i;
		i = wordT'(imm);
		encJ = {i[20], i[10:1], i[11], i[19:12], 5'(rd), OP_JAL};
	endfunction

	// initial data memory contents
	function automatic wordT fillWord(wordT a);
		fillWord = (a * 32'h9E37_79B9) ^ 32'h5A5A_5A5A;
	endfunction

	task automatic step(wordT inst, wordT atPc);
		progInst.push_back(inst);
		progPc.push_back(atPc);
		progHasStore.push_back(1'b0);
		progStAddr.push_back('0);
		progStData.push_back('0);
	endtask

	task automatic stepStore(wordT inst, wordT atPc, wordT a, wordT d);
		progInst.push_back(inst);
		progPc.push_back(atPc);
		progHasStore.push_back(1'b1);
		progStAddr.push_back(a);
		progStData.push_back(d);
	endtask

	task automatic failRun(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run aborted");
	endtask

	task automatic checkWord(string what, wordT got, wordT exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic checkFlag(string what, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic int wordIndex(wordT a);
		wordIndex = int'((a - DATA_BASE) >> 2);
	endfunction

	task automatic checkRange(wordT a);
		if (a < DATA_BASE || a >= DATA_BASE + 4 * DATA_WORDS || a[1:0] != 2'b00) begin
			failRun($sformatf("data access outside the data memory at %h", a));
		end
	endtask

	task automatic serveFetch(int i);
		int d;
		checkWord("fetch pc", pc, progPc[i]);
		pendingStore = progHasStore[i];
		expAddr = progStAddr[i];
		expData = progStData[i];
		d = $urandom_range(3);
		repeat (d) begin
			@(negedge clk);
			checkFlag("instReqValid while unacknowledged", instReqValid, 1'b1);
		end
		instReqAck = 1'b1;
		@(negedge clk);
		instReqAck = 1'b0;
		d = $urandom_range(3);
		repeat (d) @(negedge clk);
		checkFlag("instAck", instAck, 1'b1);
		instruction = progInst[i];
		instValid = 1'b1;
		@(negedge clk);
		instValid = 1'b0;
		instruction = '0;
	endtask

	task automatic serveWrite();
		int d;
		if (!pendingStore) begin
			failRun($sformatf("unexpected store to %h at time %0t", address, $time));
		end
		checkWord("store address", address, expAddr);
		checkWord("store data", writeData, expData);
		checkRange(address);
		dmem[wordIndex(address)] = writeData;
		pendingStore = 1'b0;
		d = $urandom_range(3);
		repeat (d) begin
			@(negedge clk);
			checkFlag("memWrite while unacknowledged", memWrite, 1'b1);
		end
		memReqAck = 1'b1;
		@(negedge clk);
		memReqAck = 1'b0;
	endtask

	task automatic serveRead();
		int d;
		wordT data;
		checkRange(address);
		data = dmem[wordIndex(address)];
		d = $urandom_range(3);
		repeat (d) begin
			@(negedge clk);
			checkFlag("memRead while unacknowledged", memRead, 1'b1);
		end
		memReqAck = 1'b1;
		@(negedge clk);
		memReqAck = 1'b0;
		d = $urandom_range(3);
		repeat (d) @(negedge clk);
		checkFlag("readDataAck", readDataAck, 1'b1);
		readData = data;
		readDataValid = 1'b1;
		@(negedge clk);
		readDataValid = 1'b0;
	endtask

	task automatic buildProgram();
		step(encI(32'h100, 0, 0, 1, OP_IMM), 0);
		step(encI(25, 0, 0, 2, OP_IMM), 4);
		step(encI(-7, 0, 0, 3, OP_IMM), 8);
		step(encR(0, 3, 2, 0, 4), 12);
		stepStore(encS(0, 4, 1), 16, 32'h100, 32'h0000_0012);
		step(encR(32, 3, 2, 0, 5), 20);
		stepStore(encS(4, 5, 1), 24, 32'h104, 32'h0000_0020);
		step(encR(0, 2, 3, 2, 6), 28);
		step(encR(0, 2, 3, 3, 7), 32);
		step(encR(0, 3, 2, 4, 8), 36);
		stepStore(encS(8, 8, 1), 40, 32'h108, 32'hFFFF_FFE0);
		step(encR(32, 6, 3, 5, 9), 44);
		step(encR(0, 6, 3, 5, 10), 48);
		step(encR(0, 2, 2, 1, 11), 52);
		stepStore(encS(12, 9, 1), 56, 32'h10C, 32'hFFFF_FFFC);
		stepStore(encS(16, 10, 1), 60, 32'h110, 32'h7FFF_FFFC);
		stepStore(encS(20, 11, 1), 64, 32'h114, 32'h3200_0000);
		step(encI(32'hF0, 3, 7, 12, OP_IMM), 68);
		step(encI(5, 12, 6, 13, OP_IMM), 72);
		step(encI(-1, 13, 4, 14, OP_IMM), 76);
		stepStore(encS(24, 14, 1), 80, 32'h118, 32'hFFFF_FF0A);
		step(encI(-6, 3, 2, 15, OP_IMM), 84);
		step(encI(3, 15, 1, 16, OP_IMM), 88);
		step(encR(0, 7, 16, 0, 17), 92);
		stepStore(encS(28, 17, 1), 96, 32'h11C, 32'h0000_0008);
		// branches, taken and not taken
		step(encB(8, 2, 2, 0), 100);
		step(encB(8, 2, 2, 1), 108);
		step(encB(12, 2, 3, 4), 112);
		step(encB(8, 2, 3, 5), 124);
		step(encB(8, 3, 2, 6), 128);
		step(encB(8, 3, 2, 7), 136);
		step(encJ(12, 19), 140);
		stepStore(encS(32, 19, 1), 152, 32'h120, 32'd144);
		step(encI(176, 0, 0, 20, OP_IMM), 156);
		step(encI(4, 20, 0, 21, OP_JALR), 160);
		stepStore(encS(36, 21, 1), 180, 32'h124, 32'd164);
		step(encI(60, 1, 2, 22, OP_LOAD), 184);
		stepStore(encS(40, 22, 1), 188, 32'h128, fillWord(32'h13C));
		step(encI(0, 1, 2, 23, OP_LOAD), 192);
		stepStore(encS(44, 23, 1), 196, 32'h12C, 32'h0000_0012);
		step(encU(32'hABCDE, 25, OP_LUI), 200);
		step(encU(1, 26, OP_AUIPC), 204);
		stepStore(encS(48, 25, 1), 208, 32'h130, 32'hABCD_E000);
		stepStore(encS(52, 26, 1), 212, 32'h134, 32'h0000_10CC);
		// unknown opcode, then jump back to zero
		step(32'h0000_007F, 216);
		step(encJ(-220, 0), 220);
		stepStore(encS(56, 5, 1), 0, 32'h138, 32'h0000_0020);
		numEntries = progInst.size();
	endtask

	initial begin
		while (numEntries == 0) @(posedge clk);
		while (cycles < numEntries * 8 * 4 + 50) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the program did not finish in %0d cycles", cycles);
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	initial begin
		int idx;
		bit done;
		rst = 1'b1;
		instReqAck = 1'b0;
		instruction = '0;
		instValid = 1'b0;
		memReqAck = 1'b0;
		readData = '0;
		readDataValid = 1'b0;
		void'($urandom(94));
		for (int i = 0; i < DATA_WORDS; i++) begin
			dmem[i] = fillWord(DATA_BASE + wordT'(4 * i));
		end
		buildProgram();
		pendingStore = 1'b0;
		repeat (4) @(negedge clk);
		checkFlag("instReqValid in reset", instReqValid, 1'b0);
		rst = 1'b0;
		idx = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (idx == 0) begin
				checkFlag("memWrite before first fetch", memWrite, 1'b0);
				checkFlag("memRead before first fetch", memRead, 1'b0);
			end
			if (memWrite) begin
				serveWrite();
			end else if (memRead) begin
				serveRead();
			end else if (instReqValid) begin
				if (pendingStore) begin
					failRun($sformatf("store expected before fetch at %h never came", pc));
				end
				if (idx == numEntries) begin
					done = 1'b1;
				end else begin
					serveFetch(idx);
					idx++;
				end
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* cpuTop_assert.sv */
`default_nettype none

module cpuTopAssert (
	input logic clk,
	input logic rst,
	input logic instReqValid,
	input logic instReqAck,
	input logic memWrite,
	input logic memRead,
	input logic memReqAck
);

	noReadWrite: assert property (@(posedge clk) disable iff (rst)
		!(memWrite && memRead))
		else $error("memWrite and memRead high together");

	fetchAlone: assert property (@(posedge clk) disable iff (rst)
		!(instReqValid && (memWrite || memRead)))
		else $error("fetch request overlaps a data request");

	fetchHeld: assert property (@(posedge clk) disable iff (rst)
		instReqValid && !instReqAck |=> instReqValid)
		else $error("instReqValid dropped before instReqAck");

	// data requests hold too
	writeHeld: assert property (@(posedge clk) disable iff (rst)
		memWrite && !memReqAck |=> memWrite)
		else $error("memWrite dropped before memReqAck");

	readHeld: assert property (@(posedge clk) disable iff (rst)
		memRead && !memReqAck |=> memRead)
		else $error("memRead dropped before memReqAck");

endmodule

bind cpuTop cpuTopAssert i_cpuTopAssert (
	.clk(clk),
	.rst(rst),
	.instReqValid(instReqValid),
	.instReqAck(instReqAck),
	.memWrite(memWrite),
	.memRead(memRead),
	.memReqAck(memReqAck)
);

`default_nettype wire

/* cpuTop.sv */
`default_nettype none

module cpuTop
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	output wordT pc,
	output logic instReqValid,
	input  logic instReqAck,
	input  wordT instruction,
	input  logic instValid,
	output logic instAck,
	output wordT address,
	output logic memWrite,
	output wordT writeData,
	output logic memRead,
	input  logic memReqAck,
	input  wordT readData,
	input  logic readDataValid,
	output logic readDataAck
);

	wordT instWord;
	wordT readWord;
	wordT imm;
	wordT rdata1;
	wordT rdata2;
	wordT rfWdata;
	regAddrT rs1;
	regAddrT rs2;
	regAddrT rd;
	aluOpT aluOp;
	logic pcStall;
	logic memStall;
	logic wbStall;
	logic branchNoLink;
	logic branch;
	logic jal;
	logic jalr;
	logic isLoad;
	logic isStore;
	logic srcAPc;
	logic srcBImm;
	logic regWrite;
	logic rfWen;

	cpuSequencer i_cpuSequencer (
		.clk(clk),
		.rst(rst),
		.instReqAck(instReqAck),
		.instruction(instruction),
		.instValid(instValid),
		.memReqAck(memReqAck),
		.readData(readData),
		.readDataValid(readDataValid),
		.branchNoLink(branchNoLink),
		.isStore(isStore),
		.isLoad(isLoad),
		.instReqValid(instReqValid),
		.instAck(instAck),
		.readDataAck(readDataAck),
		.instWord(instWord),
		.readWord(readWord),
		.pcStall(pcStall),
		.memStall(memStall),
		.wbStall(wbStall)
	);

	instDecoder i_instDecoder (
		.instWord(instWord),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.aluOp(aluOp),
		.imm(imm),
		.branch(branch),
		.jal(jal),
		.jalr(jalr),
		.isLoad(isLoad),
		.isStore(isStore),
		.srcAPc(srcAPc),
		.srcBImm(srcBImm),
		.regWrite(regWrite)
	);

	regFile i_regFile (
		.clk(clk),
		.rst(rst),
		.raddr1(rs1),
		.raddr2(rs2),
		.waddr(rd),
		.wen(rfWen),
		.wdata(rfWdata),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	execUnit i_execUnit (
		.clk(clk),
		.rst(rst),
		.pcStall(pcStall),
		.memStall(memStall),
		.wbStall(wbStall),
		.aluOp(aluOp),
		.imm(imm),
		.branch(branch),
		.jal(jal),
		.jalr(jalr),
		.isLoad(isLoad),
		.isStore(isStore),
		.srcAPc(srcAPc),
		.srcBImm(srcBImm),
		.regWrite(regWrite),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.readWord(readWord),
		.pc(pc),
		.branchNoLink(branchNoLink),
		.address(address),
		.writeData(writeData),
		.memWrite(memWrite),
		.memRead(memRead),
		.rfWen(rfWen),
		.rfWdata(rfWdata)
	);

endmodule

`default_nettype wire

/* execUnit.sv */
`default_nettype none

module execUnit
	import cpuPkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  pcStall,
	input  logic  memStall,
	input  logic  wbStall,
	input  aluOpT aluOp,
	input  wordT  imm,
	input  logic  branch,
	input  logic  jal,
	input  logic  jalr,
	input  logic  isLoad,
	input  logic  isStore,
	input  logic  srcAPc,
	input  logic  srcBImm,
	input  logic  regWrite,
	input  wordT  rdata1,
	input  wordT  rdata2,
	input  wordT  readWord,
	output wordT  pc,
	output logic  branchNoLink,
	output wordT  address,
	output wordT  writeData,
	output logic  memWrite,
	output logic  memRead,
	output logic  rfWen,
	output wordT  rfWdata
);

	wordT lastPc;
	wordT aluA;
	wordT aluB;
	wordT aluResult;
	wordT target;
	wordT nextPc;
	logic zero;
	logic taken;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (!pcStall) begin
			pc <= nextPc;
		end
	end

	// pc of the current instruction once pc has moved on
	always_ff @(posedge clk) begin
		lastPc <= pc;
	end

	assign aluA = srcAPc ? lastPc : rdata1;
	assign aluB = srcBImm ? imm : rdata2;

	alu i_alu (
		.a(aluA),
		.b(aluB),
		.op(aluOp),
		.result(aluResult),
		.zero(zero)
	);

	// a nonzero compare result means taken
	assign taken = (branch && !zero) || jal || jalr;
	assign target = jalr ? ((rdata1 + imm) & ~wordT'(1)) : (pc + imm);
	assign nextPc = taken ? target : (pc + PC_STEP);
	assign branchNoLink = (branch || jal || jalr) && !regWrite;

	assign address = aluResult;
	assign writeData = rdata2;
	assign memWrite = isStore && !memStall;
	assign memRead = isLoad && !memStall;

	assign rfWen = regWrite && !wbStall;
	assign rfWdata = isLoad ? readWord : aluResult;

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu
	import cpuPkg::*;
(
	input  wordT  a,
	input  wordT  b,
	input  aluOpT op,
	output wordT  result,
	output logic  zero
);

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			SLT: result = {31'b0, lessSigned};
			SLTU: result = {31'b0, lessUnsigned};
			SNE: result = {31'b0, a != b};
			SEQ: result = {31'b0, a == b};
			SGE: result = {31'b0, !lessSigned};
			SGEU: result = {31'b0, !lessUnsigned};
			SLL: result = a << b[4:0];
			SRL: result = a >> b[4:0];
			SRA: result = wordT'($signed(a) >>> b[4:0]);
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			BYPASS: result = b;
			// return address from the old pc
			LINK: result = a + PC_STEP;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile
	import cpuPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  regAddrT raddr1,
	input  regAddrT raddr2,
	input  regAddrT waddr,
	input  logic    wen,
	input  wordT    wdata,
	output wordT    rdata1,
	output wordT    rdata2
);

	wordT regs [NUM_REGS];

	always_ff @(posedge clk) begin
		// x0 is never written
		if (!rst && wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* instDecoder.sv */
`default_nettype none

module instDecoder
	import cpuPkg::*;
(
	input  wordT    instWord,
	output regAddrT rs1,
	output regAddrT rs2,
	output regAddrT rd,
	output aluOpT   aluOp,
	output wordT    imm,
	output logic    branch,
	output logic    jal,
	output logic    jalr,
	output logic    isLoad,
	output logic    isStore,
	output logic    srcAPc,
	output logic    srcBImm,
	output logic    regWrite
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	wordT rImm;
	wordT iImm;
	wordT sImm;
	wordT bImm;
	wordT uImm;
	wordT jImm;
	logic isShift;

	function automatic aluOpT arithOp(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: arithOp = alt ? SUB : ADD;
			3'b001: arithOp = SLL;
			3'b010: arithOp = SLT;
			3'b011: arithOp = SLTU;
			3'b100: arithOp = XOR;
			3'b101: arithOp = alt ? SRA : SRL;
			3'b110: arithOp = OR;
			default: arithOp = AND;
		endcase
	endfunction

	assign opcode = instWord[6:0];
	assign funct3 = instWord[14:12];
	assign funct7 = instWord[31:25];
	assign rs1 = instWord[19:15];
	assign rs2 = instWord[24:20];
	assign rd = instWord[11:7];
	assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

	// shamt is the R format immediate
	assign rImm = {27'b0, instWord[24:20]};
	assign iImm = {{21{instWord[31]}}, instWord[30:20]};
	assign sImm = {{21{instWord[31]}}, instWord[30:25], instWord[11:7]};
	assign bImm = {{20{instWord[31]}}, instWord[7], instWord[30:25], instWord[11:8], 1'b0};
	assign uImm = {instWord[31:12], 12'b0};
	assign jImm = {{12{instWord[31]}}, instWord[19:12], instWord[20], instWord[30:21], 1'b0};

	always_comb begin
		aluOp = ADD;
		imm = '0;
		branch = 1'b0;
		jal = 1'b0;
		jalr = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		srcAPc = 1'b0;
		srcBImm = 1'b0;
		regWrite = 1'b0;
		case (opcode)
			OP_REG: begin
				aluOp = arithOp(funct3, funct7[5]);
				imm = rImm;
				regWrite = (funct7 == 7'b0000000)
					|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			OP_IMM: begin
				// funct7 only qualifies the shifts
				aluOp = arithOp(funct3, (funct3 == 3'b101) && funct7[5]);
				imm = isShift ? rImm : iImm;
				srcBImm = 1'b1;
				regWrite = !isShift || funct7 == 7'b0000000
					|| (funct3 == 3'b101 && funct7 == 7'b0100000);
			end
			OP_LOAD: begin
				imm = iImm;
				srcBImm = 1'b1;
				isLoad = (funct3 == 3'b010);
				regWrite = (funct3 == 3'b010);
			end
			OP_STORE: begin
				imm = sImm;
				srcBImm = 1'b1;
				isStore = (funct3 == 3'b010);
			end
			OP_BRANCH: begin
				imm = bImm;
				branch = (funct3 != 3'b010) && (funct3 != 3'b011);
				case (funct3)
					3'b000: aluOp = SEQ;
					3'b001: aluOp = SNE;
					3'b100: aluOp = SLT;
					3'b101: aluOp = SGE;
					3'b110: aluOp = SLTU;
					default: aluOp = SGEU;
				endcase
			end
			OP_LUI: begin
				aluOp = BYPASS;
				imm = uImm;
				srcBImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_AUIPC: begin
				imm = uImm;
				srcAPc = 1'b1;
				srcBImm = 1'b1;
				regWrite = 1'b1;
			end
			OP_JAL: begin
				aluOp = LINK;
				imm = jImm;
				jal = 1'b1;
				srcAPc = 1'b1;
				regWrite = 1'b1;
			end
			OP_JALR: begin
				aluOp = LINK;
				imm = iImm;
				jalr = (funct3 == 3'b000);
				srcAPc = 1'b1;
				regWrite = (funct3 == 3'b000);
			end
			default: begin
				// unknown opcode, behaves as a nop
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* cpuSequencer.sv */
`default_nettype none

module cpuSequencer
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic instReqAck,
	input  wordT instruction,
	input  logic instValid,
	input  logic memReqAck,
	input  wordT readData,
	input  logic readDataValid,
	input  logic branchNoLink,
	input  logic isStore,
	input  logic isLoad,
	output logic instReqValid,
	output logic instAck,
	output logic readDataAck,
	output wordT instWord,
	output wordT readWord,
	output logic pcStall,
	output logic memStall,
	output logic wbStall
);

	seqStateT state;
	seqStateT nextState;
	wordT instReg;
	wordT readReg;
	logic instTake;
	logic readTake;
	logic [5:0] ctrl;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_RESET;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			S_RESET: nextState = S_FETCH;
			S_FETCH: nextState = instReqAck ? S_INST_WAIT : S_FETCH;
			S_INST_WAIT: nextState = instValid ? S_DECODE : S_INST_WAIT;
			S_DECODE: nextState = S_EXECUTE;
			// jumps and branches without a link are done here
			S_EXECUTE: nextState = branchNoLink ? S_FETCH : S_MEM;
			S_MEM: begin
				if (isLoad) begin
					nextState = memReqAck ? S_READ_WAIT : S_MEM;
				end else if (!isStore || memReqAck) begin
					nextState = S_FETCH;
				end
			end
			S_READ_WAIT: nextState = readDataValid ? S_WRITEBACK : S_READ_WAIT;
			S_WRITEBACK: nextState = S_FETCH;
		endcase
	end

	// instReqValid, instAck, readDataAck, pcStall, memStall, wbStall
	always_comb begin
		case (state)
			S_FETCH: ctrl = 6'b100111;
			S_INST_WAIT: ctrl = 6'b010111;
			S_EXECUTE: ctrl = 6'b000011;
			S_MEM: ctrl = isLoad ? 6'b000101 : 6'b000100;
			S_READ_WAIT: ctrl = 6'b001111;
			S_WRITEBACK: ctrl = 6'b000110;
			default: ctrl = 6'b000111;
		endcase
	end

	assign {instReqValid, instAck, readDataAck, pcStall, memStall, wbStall} = ctrl;

	assign instTake = instValid && instAck;
	assign readTake = readDataValid && readDataAck;

	always_ff @(posedge clk) begin
		if (instTake) begin
			instReg <= instruction;
		end
		if (readTake) begin
			readReg <= readData;
		end
	end

	// decode can start in the capture cycle
	assign instWord = instTake ? instruction : instReg;
	assign readWord = readReg;

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] wordT;
	typedef logic [$clog2(NUM_REGS)-1:0] regAddrT;

	localparam wordT PC_STEP = 32'd4;
	localparam wordT RESET_PC = 32'h0000_0000;

	// major opcodes, bits [6:0]
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;

	// compares give 1 when the matching branch is taken
	typedef enum logic [4:0] {
		ADD = 5'b00000,
		SUB = 5'b00001,
		SLT = 5'b01000,
		SLTU = 5'b01001,
		SNE = 5'b01010,
		SEQ = 5'b01011,
		SGE = 5'b01100,
		SGEU = 5'b01101,
		SLL = 5'b10000,
		SRL = 5'b10001,
		SRA = 5'b10010,
		AND = 5'b10100,
		OR = 5'b10101,
		XOR = 5'b10110,
		BYPASS = 5'b11000,
		LINK = 5'b11001
	} aluOpT;

	typedef enum logic [2:0] {
		S_RESET = 3'b000,
		S_FETCH = 3'b001,
		S_INST_WAIT = 3'b010,
		S_DECODE = 3'b011,
		S_EXECUTE = 3'b100,
		S_MEM = 3'b101,
		S_READ_WAIT = 3'b110,
		S_WRITEBACK = 3'b111
	} seqStateT;

endpackage

`default_nettype wire
